// File: design/edge_pkg.sv
package edge_pkg;

  // **********************************************************************
  // Frame geometry
  // **********************************************************************

  localparam int IMG_COLS = 6;
  localparam int IMG_ROWS = 5;

  // Counters cover the larger of the two dimensions.
  localparam int CNT_W = $clog2((IMG_COLS > IMG_ROWS) ? IMG_COLS : IMG_ROWS);

  // **********************************************************************
  // Kernel
  // **********************************************************************

  // Register stages between window-valid and edge output.
  localparam int KERNEL_LAT = 2;

  // Signed gradient width, enough for +/- 4 * 255.
  localparam int GRAD_W = 11;

  // **********************************************************************
  // Payload types
  // **********************************************************************

  typedef logic [7:0] pixel_t;

  // Vertical slice of three rows at one column.
  typedef struct packed {
    pixel_t top;
    pixel_t mid;
    pixel_t bot;
  } column_t;

  // Right column is the newest, left column the oldest.
  typedef struct packed {
    pixel_t tl;
    pixel_t tc;
    pixel_t tr;
    pixel_t ml;
    pixel_t mc;
    pixel_t mr;
    pixel_t bl;
    pixel_t bc;
    pixel_t br;
  } window_t;

endpackage

// File: design/line_buffer.sv
`timescale 1ns/1ns

module line_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_en_i,
  input  logic [edge_pkg::CNT_W-1:0] col_addr_i,
  input  edge_pkg::pixel_t           pix_i,
  output edge_pkg::column_t          column_o
);

  // Row r-1 and row r-2 storage.
  edge_pkg::pixel_t row1_mem [edge_pkg::IMG_COLS];
  edge_pkg::pixel_t row2_mem [edge_pkg::IMG_COLS];

  // **********************************************************************
  // Asynchronous read, column is ready in the strobe cycle
  // **********************************************************************

  always_comb begin
    column_o.top = row2_mem[col_addr_i];
    column_o.mid = row1_mem[col_addr_i];
    column_o.bot = pix_i;
  end

  // **********************************************************************
  // Write, both rows move down by one at the current column
  // **********************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < edge_pkg::IMG_COLS; i++) begin
        row1_mem[i] <= '0;
        row2_mem[i] <= '0;
      end
    end else if (wr_en_i) begin
      row2_mem[col_addr_i] <= row1_mem[col_addr_i];
      row1_mem[col_addr_i] <= pix_i;
    end
  end

endmodule

// File: design/window_datapath.sv
`timescale 1ns/1ns

module window_datapath (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clear_i,
  input  logic                       shift_i,
  input  edge_pkg::column_t          column_i,
  output edge_pkg::window_t          window_o,
  output logic [edge_pkg::CNT_W-1:0] col_o,
  output logic                       col_last_o,
  output logic                       row_last_o,
  output logic                       col_ge2_o,
  output logic                       row_ge2_o
);

  logic [edge_pkg::CNT_W-1:0] col_q;
  logic [edge_pkg::CNT_W-1:0] row_q;
  edge_pkg::window_t          win_q;

  // **********************************************************************
  // Position counters
  // **********************************************************************

  // Flags look at the counters before the update.
  assign col_last_o = (col_q == edge_pkg::CNT_W'(edge_pkg::IMG_COLS - 1));
  assign row_last_o = (row_q == edge_pkg::CNT_W'(edge_pkg::IMG_ROWS - 1));
  assign col_ge2_o  = (col_q >= edge_pkg::CNT_W'(2));
  assign row_ge2_o  = (row_q >= edge_pkg::CNT_W'(2));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (clear_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (shift_i) begin
      if (col_last_o) begin
        col_q <= '0;
        if (row_last_o) begin
          row_q <= '0;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  assign col_o = col_q;

  // **********************************************************************
  // 3x3 window, advances only on a strobe
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (shift_i) begin
      win_q.tl <= win_q.tc;
      win_q.tc <= win_q.tr;
      win_q.tr <= column_i.top;

      win_q.ml <= win_q.mc;
      win_q.mc <= win_q.mr;
      win_q.mr <= column_i.mid;

      win_q.bl <= win_q.bc;
      win_q.bc <= win_q.br;
      win_q.br <= column_i.bot;
    end
  end

  assign window_o = win_q;

endmodule

// File: design/frame_ctrl.sv
`timescale 1ns/1ns

module frame_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  input  logic pix_valid_i,
  input  logic col_last_i,
  input  logic row_last_i,
  input  logic col_ge2_i,
  input  logic row_ge2_i,
  output logic clear_o,
  output logic shift_o,
  output logic win_valid_o,
  output logic frame_done_o
);

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_t;

  state_t                          state_q;
  logic                            clear_q;
  logic                            win_valid_q;
  logic                            last_q;
  logic [edge_pkg::KERNEL_LAT-1:0] done_pipe_q;

  // Strobes pass only while running; the clear cycle is still idle.
  assign shift_o = (state_q == ST_RUN) && pix_valid_i;

  // **********************************************************************
  // State and clear pulse
  // **********************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      clear_q <= 1'b0;
    end else begin
      clear_q <= start_i;
      if (start_i) begin
        // Restart, counters clear before run.
        state_q <= ST_IDLE;
      end else if (clear_q) begin
        state_q <= ST_RUN;
      end else if (shift_o && col_last_i && row_last_i) begin
        state_q <= ST_IDLE;
      end
    end
  end

  // **********************************************************************
  // Window valid and frame done timing
  // **********************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_valid_q <= 1'b0;
      last_q      <= 1'b0;
      done_pipe_q <= '0;
    end else begin
      win_valid_q    <= shift_o && col_ge2_i && row_ge2_i;
      last_q         <= shift_o && col_last_i && row_last_i;
      // Follows the last window through the kernel stages.
      done_pipe_q[0] <= last_q;
      for (int i = 1; i < edge_pkg::KERNEL_LAT; i++) begin
        done_pipe_q[i] <= done_pipe_q[i-1];
      end
    end
  end

  assign clear_o      = clear_q;
  assign win_valid_o  = win_valid_q;
  assign frame_done_o = done_pipe_q[edge_pkg::KERNEL_LAT-1];

endmodule

// File: design/sobel_kernel.sv
`timescale 1ns/1ns

module sobel_kernel (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_i,
  input  edge_pkg::window_t window_i,
  output logic              valid_o,
  output edge_pkg::pixel_t  edge_o
);

  localparam int GW = edge_pkg::GRAD_W;

  logic        [GW-1:0] gx_pos;
  logic        [GW-1:0] gx_neg;
  logic        [GW-1:0] gy_pos;
  logic        [GW-1:0] gy_neg;
  logic signed [GW-1:0] gx_q;
  logic signed [GW-1:0] gy_q;
  logic        [GW-1:0] gx_abs;
  logic        [GW-1:0] gy_abs;
  logic        [GW:0]   mag;
  logic                 valid1_q;
  logic                 valid2_q;
  edge_pkg::pixel_t     edge_q;

  // **********************************************************************
  // Stage 1, horizontal and vertical gradients
  // **********************************************************************

  always_comb begin
    gx_pos = GW'(window_i.tr) + (GW'(window_i.mr) << 1) + GW'(window_i.br);
    gx_neg = GW'(window_i.tl) + (GW'(window_i.ml) << 1) + GW'(window_i.bl);
    gy_pos = GW'(window_i.bl) + (GW'(window_i.bc) << 1) + GW'(window_i.br);
    gy_neg = GW'(window_i.tl) + (GW'(window_i.tc) << 1) + GW'(window_i.tr);
  end

  always_ff @(posedge clk) begin
    gx_q <= signed'(gx_pos - gx_neg);
    gy_q <= signed'(gy_pos - gy_neg);
  end

  // **********************************************************************
  // Stage 2, magnitude with saturation
  // **********************************************************************

  always_comb begin
    gx_abs = gx_q[GW-1] ? GW'(-gx_q) : GW'(gx_q);
    gy_abs = gy_q[GW-1] ? GW'(-gy_q) : GW'(gy_q);
    mag    = (GW+1)'(gx_abs) + (GW+1)'(gy_abs);
  end

  always_ff @(posedge clk) begin
    edge_q <= (mag > (GW+1)'(255)) ? 8'hff : mag[7:0];
  end

  // Valid travels beside the data.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid1_q <= 1'b0;
      valid2_q <= 1'b0;
    end else begin
      valid1_q <= valid_i;
      valid2_q <= valid1_q;
    end
  end

  assign valid_o = valid2_q;
  assign edge_o  = edge_q;

endmodule

// File: design/edge_detect_top.sv
`timescale 1ns/1ns

module edge_detect_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_i,
  input  logic             pix_valid_i,
  input  edge_pkg::pixel_t pix_i,
  output logic             edge_valid_o,
  output edge_pkg::pixel_t edge_o,
  output logic             frame_done_o
);

  edge_pkg::column_t          column;
  edge_pkg::window_t          window;
  logic [edge_pkg::CNT_W-1:0] col;
  logic                       col_last;
  logic                       row_last;
  logic                       col_ge2;
  logic                       row_ge2;
  logic                       clear;
  logic                       shift;
  logic                       win_valid;

  line_buffer line_buffer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en_i    (shift),
    .col_addr_i (col),
    .pix_i      (pix_i),
    .column_o   (column)
  );

  window_datapath window_datapath_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (clear),
    .shift_i    (shift),
    .column_i   (column),
    .window_o   (window),
    .col_o      (col),
    .col_last_o (col_last),
    .row_last_o (row_last),
    .col_ge2_o  (col_ge2),
    .row_ge2_o  (row_ge2)
  );

  frame_ctrl frame_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .pix_valid_i  (pix_valid_i),
    .col_last_i   (col_last),
    .row_last_i   (row_last),
    .col_ge2_i    (col_ge2),
    .row_ge2_i    (row_ge2),
    .clear_o      (clear),
    .shift_o      (shift),
    .win_valid_o  (win_valid),
    .frame_done_o (frame_done_o)
  );

  sobel_kernel sobel_kernel_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (win_valid),
    .window_i (window),
    .valid_o  (edge_valid_o),
    .edge_o   (edge_o)
  );

endmodule

// File: tb/edge_detect_tb.sv
`timescale 1ns/1ns

module edge_detect_tb;

  localparam int NPIX    = edge_pkg::IMG_COLS * edge_pkg::IMG_ROWS;
  localparam int NOUT    = (edge_pkg::IMG_COLS - 2) * (edge_pkg::IMG_ROWS - 2);
  localparam int NVEC    = NPIX + NOUT;
  // Clock edges from the edge that drives a pixel to its edge_valid_o.
  localparam int OUT_LAT = 3;
  // Gapped frame takes up to 4 cycles per pixel, the other passes fit in one more such frame.
  localparam int MAX_CYCLES = 2 * NPIX * 4 + 64;

  typedef struct packed {
    int idx;
    int exp_cycle;
  } pending_t;

  logic             clk;
  logic             rst_n;
  logic             start_i;
  logic             pix_valid_i;
  edge_pkg::pixel_t pix_i;
  logic             edge_valid_o;
  edge_pkg::pixel_t edge_o;
  logic             frame_done_o;

  edge_pkg::pixel_t vec_mem [NVEC];
  pending_t         pend_q [$];

  int    seed = 39;
  int    cycle_cnt = 0;
  int    check_cnt = 0;
  int    mismatch_cnt = 0;
  int    error_cnt = 0;
  int    out_cnt = 0;
  int    done_cnt = 0;
  int    frame_out_base = 0;
  string frame_name = "idle";

  edge_detect_top edge_detect_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .pix_valid_i  (pix_valid_i),
    .pix_i        (pix_i),
    .edge_valid_o (edge_valid_o),
    .edge_o       (edge_o),
    .frame_done_o (frame_done_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // **********************************************************************
  // Compare tasks and run end
  // **********************************************************************

  task automatic check_pixel(input string name, input edge_pkg::pixel_t exp,
                             input edge_pkg::pixel_t act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    check_cnt++;
    if (act != exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d mismatches, %0d other errors",
             check_cnt, mismatch_cnt, error_cnt);
    if (mismatch_cnt == 0 && error_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // **********************************************************************
  // Stimulus
  // **********************************************************************

  task automatic start_frame();
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    // Clear cycle, the controller runs from the next edge.
    @(posedge clk);
  endtask

  // Streams the vector frame; windows completed by a pixel are queued for the monitor.
  task automatic stream_frame(input bit with_gaps, input bit expect_out);
    int       i;
    int       gap;
    int       row;
    int       col;
    pending_t p;
    for (i = 0; i < NPIX; i++) begin
      gap = with_gaps ? ($random(seed) & 3) : 0;
      if (gap > 0) begin
        pix_valid_i <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      pix_valid_i <= 1'b1;
      pix_i       <= vec_mem[i];
      row = i / edge_pkg::IMG_COLS;
      col = i % edge_pkg::IMG_COLS;
      if (expect_out && row >= 2 && col >= 2) begin
        p.idx       = (row - 2) * (edge_pkg::IMG_COLS - 2) + (col - 2);
        // Count of this drive edge, then OUT_LAT edges later.
        p.exp_cycle = cycle_cnt + 1 + OUT_LAT;
        pend_q.push_back(p);
      end
      @(posedge clk);
    end
    pix_valid_i <= 1'b0;
  endtask

  task automatic run_frame(input string name, input bit with_gaps);
    int out_base;
    int done_base;
    out_base       = out_cnt;
    done_base      = done_cnt;
    frame_out_base = out_cnt;
    frame_name     = name;
    start_frame();
    stream_frame(with_gaps, 1'b1);
    // Stop at the done pulse or the last edge, whichever comes first.
    wait ((done_cnt > done_base) || (out_cnt - out_base >= NOUT));
    @(posedge clk);
    check_count({name, " edge outputs"}, NOUT, out_cnt - out_base);
    check_count({name, " done pulses"}, 1, done_cnt - done_base);
  endtask

  // **********************************************************************
  // Monitor
  // **********************************************************************

  initial begin
    pending_t p;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (edge_valid_o) begin
          out_cnt++;
          if (pend_q.size() == 0) begin
            error_cnt++;
            $display("ERROR: edge_valid_o at cycle %0d with no window pending", cycle_cnt);
          end else begin
            p = pend_q.pop_front();
            check_pixel($sformatf("%s edge %0d", frame_name, p.idx),
                        vec_mem[NPIX + p.idx], edge_o);
            check_count($sformatf("%s latency of edge %0d", frame_name, p.idx),
                        p.exp_cycle, cycle_cnt);
          end
        end
        if (frame_done_o) begin
          done_cnt++;
          if (!edge_valid_o) begin
            error_cnt++;
            $display("ERROR: frame_done_o at cycle %0d without an edge output", cycle_cnt);
          end
          check_count({frame_name, " outputs at frame done"}, NOUT,
                      out_cnt - frame_out_base);
        end
      end
    end
  end

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    error_cnt++;
    $display("ERROR: timeout after %0d cycles, the run did not complete", MAX_CYCLES);
    finish_run();
  end

  // **********************************************************************
  // Test sequence
  // **********************************************************************

  initial begin
    rst_n       = 1'b0;
    start_i     = 1'b0;
    pix_valid_i = 1'b0;
    pix_i       = '0;
    $readmemh("tb/edge_vectors.txt", vec_mem);
    for (int i = 0; i < NVEC; i++) begin
      if ($isunknown(vec_mem[i])) begin
        error_cnt++;
        $display("ERROR: vector file entry %0d is missing or not hex", i);
      end
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Strobes without a start are ignored.
    stream_frame(1'b0, 1'b0);
    repeat (8) @(posedge clk);
    check_count("idle edge outputs", 0, out_cnt);
    check_count("idle done pulses", 0, done_cnt);

    run_frame("gap-free frame", 1'b0);
    run_frame("gapped frame", 1'b1);
    // Starts on the edge right after the previous done pulse.
    run_frame("back-to-back frame", 1'b0);

    repeat (8) @(posedge clk);
    check_count("total edge outputs", 3 * NOUT, out_cnt);
    check_count("total done pulses", 3, done_cnt);
    if (pend_q.size() != 0) begin
      error_cnt++;
      $display("ERROR: %0d expected edge outputs never arrived", pend_q.size());
    end
    finish_run();
  end

endmodule

// File: tb/edge_vectors.txt
// One hex byte per line. First 30 lines are input pixels in raster order (6 per row).
// Last 12 lines are expected edges for window centres, rows 1..3 by columns 1..4.
0a // row 0
0c
0e
10
12
14
14 // row 1
1e
28
32
3c
46
1e // row 2
1e
1e
1e
1e
1e
00 // row 3, step to 255
00
00
ff
ff
ff
00 // row 4
00
00
ff
ff
ff
74 // centre row 1
6c
64
5c
8c // centre row 2
ff
ff
ff
78 // centre row 3
ff
ff
ff

// File: edge_detect_top.f
design/edge_pkg.sv
design/line_buffer.sv
design/window_datapath.sv
design/frame_ctrl.sv
design/sobel_kernel.sv
design/edge_detect_top.sv
tb/edge_detect_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the edge detector testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module edge_detect_tb -f edge_detect_top.f -o edge_detect_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/edge_detect_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
